// File: design/trapPkg.sv
`default_nettype none

package trapPkg;

    // data and pc width, fixed by the CSR layout
    localparam int Xlen = 64;
    localparam int CsrIdWidth = 12;

    typedef enum logic [2:0] {
        OpCsrRw = 3'd0,
        OpCsrRs = 3'd1,
        OpCsrRc = 3'd2,
        OpEcall = 3'd3,
        OpMret  = 3'd4
    } csrOpE;

    // machine-mode CSR addresses
    localparam logic [CsrIdWidth-1:0] AddrMstatus  = 12'h300;
    localparam logic [CsrIdWidth-1:0] AddrMie      = 12'h304;
    localparam logic [CsrIdWidth-1:0] AddrMtvec    = 12'h305;
    localparam logic [CsrIdWidth-1:0] AddrMscratch = 12'h340;
    localparam logic [CsrIdWidth-1:0] AddrMepc     = 12'h341;
    localparam logic [CsrIdWidth-1:0] AddrMcause   = 12'h342;
    localparam logic [CsrIdWidth-1:0] AddrMip      = 12'h344;

    // SXL/UXL = 2, MPP = machine
    localparam logic [Xlen-1:0] MstatusReset = 64'h0000_000A_0000_1800;

    localparam int MstatusMie  = 3;
    localparam int MstatusMpie = 7;
    localparam int MieMtie     = 7;
    localparam int MipMtip     = 7;

    localparam logic [Xlen-1:0] CauseEcallM = 64'd11;
    // interrupt flag in the top bit, machine timer code 7
    localparam logic [Xlen-1:0] CauseTimerM = {1'b1, 63'd7};

    // hart select width, at least one bit even for a single hart
    function automatic int hartIdWidth(input int numHarts);
        return (numHarts > 1) ? $clog2(numHarts) : 1;
    endfunction

endpackage

`default_nettype wire

// File: design/csrDispatch.sv
`default_nettype none

module csrDispatch #(
    parameter int NumHarts = 4
) (
    input  logic                                     clk,
    input  logic                                     rst,
    input  logic                                     cmdValid,
    input  logic [trapPkg::hartIdWidth(NumHarts)-1:0] cmdHart,
    input  trapPkg::csrOpE                           cmdOp,
    input  logic [trapPkg::CsrIdWidth-1:0]           cmdCsrId,
    input  logic [trapPkg::Xlen-1:0]                 cmdData,
    input  logic [trapPkg::Xlen-1:0]                 cmdPc,
    output logic [NumHarts-1:0]                      hartValid,
    output trapPkg::csrOpE                           hartOp,
    output logic [trapPkg::CsrIdWidth-1:0]           hartCsrId,
    output logic [trapPkg::Xlen-1:0]                 hartData,
    output logic [trapPkg::Xlen-1:0]                 hartPc
);

    logic cmdInRange;
    logic cmdAccept;

    // hart numbers past NumHarts are silently dropped
    assign cmdInRange = int'(cmdHart) < NumHarts;
    assign cmdAccept = cmdValid && cmdInRange;

    // one-hot strobe towards the CSR files
    always_ff @(posedge clk) begin
        if (rst) begin
            hartValid <= '0;
        end else begin
            for (int h = 0; h < NumHarts; h++) begin
                hartValid[h] <= cmdAccept && (int'(cmdHart) == h);
            end
        end
    end

    // shared command bus, only loaded for accepted commands
    always_ff @(posedge clk) begin
        if (cmdAccept) begin
            hartOp    <= cmdOp;
            hartCsrId <= cmdCsrId;
            hartData  <= cmdData;
            hartPc    <= cmdPc;
        end
    end

    // a strobe only follows an accepted command, and only to one hart
    strobeFollowsCmd: assert property (
        @(posedge clk) disable iff (rst)
        (|hartValid) |-> ($onehot(hartValid) && $past(cmdValid))
    );

endmodule

`default_nettype wire

// File: design/machineCsrFile.sv
`default_nettype none

module machineCsrFile (
    input  logic                           clk,
    input  logic                           rst,
    input  logic                           inValid,
    input  trapPkg::csrOpE                 inOp,
    input  logic [trapPkg::CsrIdWidth-1:0] inCsrId,
    input  logic [trapPkg::Xlen-1:0]       inData,
    input  logic [trapPkg::Xlen-1:0]       inPc,
    input  logic                           timerPending,
    output logic                           outValid,
    output logic [trapPkg::Xlen-1:0]       outData,
    output logic                           outIllegal,
    output logic                           outRedirect,
    output logic [trapPkg::Xlen-1:0]       outPc
);

    import trapPkg::*;

    logic [Xlen-1:0] mstatus;
    logic [Xlen-1:0] mie;
    logic [Xlen-1:0] mtvec;
    logic [Xlen-1:0] mscratch;
    logic [Xlen-1:0] mepc;
    logic [Xlen-1:0] mcause;

    logic [Xlen-1:0] mipView;
    logic [Xlen-1:0] csrOld;
    logic [Xlen-1:0] csrNew;
    logic            csrKnown;
    logic            isCsrOp;
    logic            isEcall;
    logic            isMret;
    logic            takeIrq;
    logic [Xlen-1:0] trapVector;

    // mip has no storage and shows only the live timer bit
    assign mipView = Xlen'(timerPending) << MipMtip;

    assign isCsrOp = (inOp == OpCsrRw) || (inOp == OpCsrRs) || (inOp == OpCsrRc);
    assign isEcall = inOp == OpEcall;
    assign isMret  = inOp == OpMret;

    // pending timer interrupt preempts whatever command arrives
    assign takeIrq = timerPending && mstatus[MstatusMie] && mie[MieMtie];

    // direct mode only so the mode bits are ignored
    assign trapVector = {mtvec[Xlen-1:2], 2'b00};

    // read mux
    always_comb begin
        csrKnown = 1'b1;
        case (inCsrId)
            AddrMstatus:  csrOld = mstatus;
            AddrMie:      csrOld = mie;
            AddrMtvec:    csrOld = mtvec;
            AddrMscratch: csrOld = mscratch;
            AddrMepc:     csrOld = mepc;
            AddrMcause:   csrOld = mcause;
            AddrMip:      csrOld = mipView;
            default: begin
                csrOld   = '0;
                csrKnown = 1'b0;
            end
        endcase
    end

    // write/set/clear operand computed from the old value
    always_comb begin
        case (inOp)
            OpCsrRw: csrNew = inData;
            OpCsrRs: csrNew = csrOld | inData;
            OpCsrRc: csrNew = csrOld & ~inData;
            default: csrNew = csrOld;
        endcase
    end

    // CSR state with priority irq > ecall > mret > csr access
    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus  <= MstatusReset;
            mie      <= '0;
            mtvec    <= '0;
            mscratch <= '0;
            mepc     <= '0;
            mcause   <= '0;
        end else if (inValid) begin
            if (takeIrq) begin
                mepc                 <= inPc;
                mcause               <= CauseTimerM;
                mstatus[MstatusMpie] <= mstatus[MstatusMie];
                mstatus[MstatusMie]  <= 1'b0;
            end else if (isEcall) begin
                mepc                 <= inPc;
                mcause               <= CauseEcallM;
                mstatus[MstatusMpie] <= mstatus[MstatusMie];
                mstatus[MstatusMie]  <= 1'b0;
            end else if (isMret) begin
                mstatus[MstatusMie]  <= mstatus[MstatusMpie];
                mstatus[MstatusMpie] <= 1'b1;
            end else if (isCsrOp && csrKnown) begin
                case (inCsrId)
                    AddrMstatus:  mstatus  <= csrNew;
                    AddrMie:      mie      <= csrNew;
                    AddrMtvec:    mtvec    <= csrNew;
                    AddrMscratch: mscratch <= csrNew;
                    AddrMepc:     mepc     <= csrNew;
                    AddrMcause:   mcause   <= csrNew;
                    // mip is read only here
                    default: ;
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid <= 1'b0;
        end else begin
            outValid <= inValid;
        end
    end

    // response payload
    always_ff @(posedge clk) begin
        if (inValid) begin
            outData     <= (isCsrOp && !takeIrq) ? csrOld : '0;
            outIllegal  <= isCsrOp && !takeIrq && !csrKnown;
            outRedirect <= takeIrq || isEcall || isMret;
            outPc       <= (isMret && !takeIrq) ? mepc : trapVector;
        end
    end

    // only the five defined operations reach a CSR file
    legalOp: assert property (
        @(posedge clk) disable iff (rst)
        inValid |-> (isCsrOp || isEcall || isMret)
    );

endmodule

`default_nettype wire

// File: design/machineTimer.sv
`default_nettype none

module machineTimer #(
    parameter int NumHarts = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      tmrValid,
    input  logic [trapPkg::hartIdWidth(NumHarts)-1:0] tmrHart,
    input  logic [trapPkg::Xlen-1:0]                  tmrCmp,
    output logic [NumHarts-1:0]                       timerPending
);

    import trapPkg::*;

    logic [Xlen-1:0] mtime;
    logic [Xlen-1:0] mtimecmp [NumHarts];

    // free-running, shared by all harts
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime <= '0;
        end else begin
            mtime <= mtime + 1'b1;
        end
    end

    // all ones keeps the compare from ever firing after reset
    always_ff @(posedge clk) begin
        if (rst) begin
            for (int h = 0; h < NumHarts; h++) begin
                mtimecmp[h] <= '1;
            end
        end else if (tmrValid) begin
            for (int h = 0; h < NumHarts; h++) begin
                if (int'(tmrHart) == h) begin
                    mtimecmp[h] <= tmrCmp;
                end
            end
        end
    end

    // registered compare, a new mtimecmp shows up one cycle after it lands
    always_ff @(posedge clk) begin
        if (rst) begin
            timerPending <= '0;
        end else begin
            for (int h = 0; h < NumHarts; h++) begin
                timerPending[h] <= mtime >= mtimecmp[h];
            end
        end
    end

endmodule

`default_nettype wire

// File: design/responseCollect.sv
`default_nettype none

module responseCollect #(
    parameter int NumHarts = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic [NumHarts-1:0]                       hartOutValid,
    input  logic [trapPkg::Xlen-1:0]                  hartOutData [NumHarts],
    input  logic [NumHarts-1:0]                       hartOutIllegal,
    input  logic [NumHarts-1:0]                       hartOutRedirect,
    input  logic [trapPkg::Xlen-1:0]                  hartOutPc [NumHarts],
    output logic                                      respValid,
    output logic [trapPkg::hartIdWidth(NumHarts)-1:0] respHart,
    output logic [trapPkg::Xlen-1:0]                  respData,
    output logic                                      respIllegal,
    output logic                                      respRedirect,
    output logic [trapPkg::Xlen-1:0]                  respPc
);

    import trapPkg::*;

    localparam int HartW = hartIdWidth(NumHarts);

    logic [HartW-1:0] selHart;
    logic [Xlen-1:0]  selData;
    logic             selIllegal;
    logic             selRedirect;
    logic [Xlen-1:0]  selPc;

    // at most one hart answers per cycle, so a plain scan is enough
    always_comb begin
        selHart     = '0;
        selData     = '0;
        selIllegal  = 1'b0;
        selRedirect = 1'b0;
        selPc       = '0;
        for (int h = 0; h < NumHarts; h++) begin
            if (hartOutValid[h]) begin
                selHart     = HartW'(h);
                selData     = hartOutData[h];
                selIllegal  = hartOutIllegal[h];
                selRedirect = hartOutRedirect[h];
                selPc       = hartOutPc[h];
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            respValid <= 1'b0;
        end else begin
            respValid <= |hartOutValid;
        end
    end

    always_ff @(posedge clk) begin
        if (|hartOutValid) begin
            respHart     <= selHart;
            respData     <= selData;
            respIllegal  <= selIllegal;
            respRedirect <= selRedirect;
            respPc       <= selPc;
        end
    end

    // the dispatcher strobes one hart per cycle and all CSR files share latency
    singleResponder: assert property (
        @(posedge clk) disable iff (rst)
        $onehot0(hartOutValid)
    );

endmodule

`default_nettype wire

// File: design/trapCsrSystem.sv
`default_nettype none

module trapCsrSystem #(
    parameter int NumHarts = 4
) (
    input  logic                                      clk,
    input  logic                                      rst,
    input  logic                                      cmdValid,
    input  logic [trapPkg::hartIdWidth(NumHarts)-1:0] cmdHart,
    input  trapPkg::csrOpE                            cmdOp,
    input  logic [trapPkg::CsrIdWidth-1:0]            cmdCsrId,
    input  logic [trapPkg::Xlen-1:0]                  cmdData,
    input  logic [trapPkg::Xlen-1:0]                  cmdPc,
    input  logic                                      tmrValid,
    input  logic [trapPkg::hartIdWidth(NumHarts)-1:0] tmrHart,
    input  logic [trapPkg::Xlen-1:0]                  tmrCmp,
    output logic                                      respValid,
    output logic [trapPkg::hartIdWidth(NumHarts)-1:0] respHart,
    output logic [trapPkg::Xlen-1:0]                  respData,
    output logic                                      respIllegal,
    output logic                                      respRedirect,
    output logic [trapPkg::Xlen-1:0]                  respPc
);

    import trapPkg::*;

    // shared command bus
    logic [NumHarts-1:0]   hartValid;
    csrOpE                 hartOp;
    logic [CsrIdWidth-1:0] hartCsrId;
    logic [Xlen-1:0]       hartData;
    logic [Xlen-1:0]       hartPc;

    logic [NumHarts-1:0]   timerPending;

    // per-hart responses
    logic [NumHarts-1:0]   hartOutValid;
    logic [Xlen-1:0]       hartOutData [NumHarts];
    logic [NumHarts-1:0]   hartOutIllegal;
    logic [NumHarts-1:0]   hartOutRedirect;
    logic [Xlen-1:0]       hartOutPc [NumHarts];

    csrDispatch #(
        .NumHarts(NumHarts)
    ) dispatch_i (
        .clk      (clk),
        .rst      (rst),
        .cmdValid (cmdValid),
        .cmdHart  (cmdHart),
        .cmdOp    (cmdOp),
        .cmdCsrId (cmdCsrId),
        .cmdData  (cmdData),
        .cmdPc    (cmdPc),
        .hartValid(hartValid),
        .hartOp   (hartOp),
        .hartCsrId(hartCsrId),
        .hartData (hartData),
        .hartPc   (hartPc)
    );

    machineTimer #(
        .NumHarts(NumHarts)
    ) timer_i (
        .clk         (clk),
        .rst         (rst),
        .tmrValid    (tmrValid),
        .tmrHart     (tmrHart),
        .tmrCmp      (tmrCmp),
        .timerPending(timerPending)
    );

    for (genvar h = 0; h < NumHarts; h++) begin : gHart
        machineCsrFile csrFile_i (
            .clk         (clk),
            .rst         (rst),
            .inValid     (hartValid[h]),
            .inOp        (hartOp),
            .inCsrId     (hartCsrId),
            .inData      (hartData),
            .inPc        (hartPc),
            .timerPending(timerPending[h]),
            .outValid    (hartOutValid[h]),
            .outData     (hartOutData[h]),
            .outIllegal  (hartOutIllegal[h]),
            .outRedirect (hartOutRedirect[h]),
            .outPc       (hartOutPc[h])
        );
    end

    responseCollect #(
        .NumHarts(NumHarts)
    ) collect_i (
        .clk            (clk),
        .rst            (rst),
        .hartOutValid   (hartOutValid),
        .hartOutData    (hartOutData),
        .hartOutIllegal (hartOutIllegal),
        .hartOutRedirect(hartOutRedirect),
        .hartOutPc      (hartOutPc),
        .respValid      (respValid),
        .respHart       (respHart),
        .respData       (respData),
        .respIllegal    (respIllegal),
        .respRedirect   (respRedirect),
        .respPc         (respPc)
    );

endmodule

`default_nettype wire

// File: verif/trapCsrSystemTb.sv
`default_nettype none

module trapCsrSystemTb;

    timeunit 1ns;
    timeprecision 1ps;

    import trapPkg::*;

    localparam int NumHarts = 4;
    localparam int HartW = hartIdWidth(NumHarts);
    // about 400 cycles of tests, the rest is margin
    localparam int CycleLimit = 3000;

    typedef struct packed {
        logic [HartW-1:0] hart;
        logic [Xlen-1:0]  data;
        logic             illegal;
        logic             redirect;
        logic [Xlen-1:0]  pc;
    } respT;

    logic                  clk;
    logic                  rst;
    logic                  cmdValid;
    logic [HartW-1:0]      cmdHart;
    csrOpE                 cmdOp;
    logic [CsrIdWidth-1:0] cmdCsrId;
    logic [Xlen-1:0]       cmdData;
    logic [Xlen-1:0]       cmdPc;
    logic                  tmrValid;
    logic [HartW-1:0]      tmrHart;
    logic [Xlen-1:0]       tmrCmp;
    logic                  respValid;
    logic [HartW-1:0]      respHart;
    logic [Xlen-1:0]       respData;
    logic                  respIllegal;
    logic                  respRedirect;
    logic [Xlen-1:0]       respPc;

    // reference copy of each hart's CSRs
    logic [Xlen-1:0] mstatusM [NumHarts];
    logic [Xlen-1:0] mieM [NumHarts];
    logic [Xlen-1:0] mtvecM [NumHarts];
    logic [Xlen-1:0] mscratchM [NumHarts];
    logic [Xlen-1:0] mepcM [NumHarts];
    logic [Xlen-1:0] mcauseM [NumHarts];
    logic            pendM [NumHarts];

    respT   expQ [$];
    respT   expCur = '0;
    integer seed = 78584;
    int     errorCount = 0;
    int     respChecked = 0;
    int     cycleCount = 0;

    trapCsrSystem #(
        .NumHarts(NumHarts)
    ) trapCsrSystem_i (
        .clk(clk), .rst(rst),
        .cmdValid(cmdValid), .cmdHart(cmdHart), .cmdOp(cmdOp),
        .cmdCsrId(cmdCsrId), .cmdData(cmdData), .cmdPc(cmdPc),
        .tmrValid(tmrValid), .tmrHart(tmrHart), .tmrCmp(tmrCmp),
        .respValid(respValid), .respHart(respHart), .respData(respData),
        .respIllegal(respIllegal), .respRedirect(respRedirect), .respPc(respPc)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
    end

    initial begin
        wait (cycleCount == CycleLimit);
        $display("timeout: run did not finish within %0d cycles", CycleLimit);
        $display("Checks failed");
        $finish;
    end

    task automatic reportMismatch(input string name, input logic [Xlen-1:0] expV,
                                  input logic [Xlen-1:0] actV);
        errorCount++;
        $display("CHECK FAILED %s expected 0x%h actual 0x%h at %0t", name, expV, actV, $time);
    endtask

    task automatic noteFailure(input string what);
        errorCount++;
        $display("%s at %0t", what, $time);
    endtask

    // the expected entry is loaded half a cycle before the response is sampled
    always @(negedge clk) begin
        if (respValid) begin
            if (expQ.size() > 0) begin
                expCur = expQ.pop_front();
                respChecked++;
            end else begin
                expCur = '0;
            end
        end
    end

    respHartOk: assert property (@(posedge clk) disable iff (rst)
        respValid |-> respHart == expCur.hart)
        else reportMismatch("respHart", Xlen'(expCur.hart), Xlen'($sampled(respHart)));
    respDataOk: assert property (@(posedge clk) disable iff (rst)
        respValid |-> respData == expCur.data)
        else reportMismatch("respData", expCur.data, $sampled(respData));
    respIllegalOk: assert property (@(posedge clk) disable iff (rst)
        respValid |-> respIllegal == expCur.illegal)
        else reportMismatch("respIllegal", Xlen'(expCur.illegal), Xlen'($sampled(respIllegal)));
    respRedirectOk: assert property (@(posedge clk) disable iff (rst)
        respValid |-> respRedirect == expCur.redirect)
        else reportMismatch("respRedirect", Xlen'(expCur.redirect),
                            Xlen'($sampled(respRedirect)));
    respPcOk: assert property (@(posedge clk) disable iff (rst)
        (respValid && expCur.redirect) |-> respPc == expCur.pc)
        else reportMismatch("respPc", expCur.pc, $sampled(respPc));
    respOnTime: assert property (@(posedge clk) disable iff (rst)
        cmdValid |-> ##3 respValid)
        else noteFailure("no response 3 cycles after a command");
    respHasCmd: assert property (@(posedge clk) disable iff (rst)
        respValid |-> $past(cmdValid, 3))
        else noteFailure("response without a command 3 cycles earlier");
    quietAfterReset: assert property (@(posedge clk)
        $fell(rst) |-> !respValid)
        else noteFailure("response valid right after reset");

    // semantics rules in priority order, applied in command order
    task automatic applyModel(input int h, input csrOpE op, input logic [CsrIdWidth-1:0] id,
                              input logic [Xlen-1:0] d, input logic [Xlen-1:0] pc,
                              output respT r);
        logic [Xlen-1:0] old;
        logic [Xlen-1:0] nxt;
        logic            known;
        r = '0;
        r.hart = HartW'(h);
        if (pendM[h] && mstatusM[h][MstatusMie] && mieM[h][MieMtie]) begin
            mepcM[h] = pc;
            mcauseM[h] = CauseTimerM;
            mstatusM[h][MstatusMpie] = mstatusM[h][MstatusMie];
            mstatusM[h][MstatusMie] = 1'b0;
            r.redirect = 1'b1;
            r.pc = mtvecM[h] & ~64'h3;
        end else if (op == OpEcall) begin
            mepcM[h] = pc;
            mcauseM[h] = CauseEcallM;
            mstatusM[h][MstatusMpie] = mstatusM[h][MstatusMie];
            mstatusM[h][MstatusMie] = 1'b0;
            r.redirect = 1'b1;
            r.pc = mtvecM[h] & ~64'h3;
        end else if (op == OpMret) begin
            r.redirect = 1'b1;
            r.pc = mepcM[h];
            mstatusM[h][MstatusMie] = mstatusM[h][MstatusMpie];
            mstatusM[h][MstatusMpie] = 1'b1;
        end else begin
            known = 1'b1;
            case (id)
                AddrMstatus:  old = mstatusM[h];
                AddrMie:      old = mieM[h];
                AddrMtvec:    old = mtvecM[h];
                AddrMscratch: old = mscratchM[h];
                AddrMepc:     old = mepcM[h];
                AddrMcause:   old = mcauseM[h];
                AddrMip:      old = Xlen'(pendM[h]) << MipMtip;
                default: begin
                    old = '0;
                    known = 1'b0;
                end
            endcase
            if (op == OpCsrRw) begin
                nxt = d;
            end else if (op == OpCsrRs) begin
                nxt = old | d;
            end else begin
                nxt = old & ~d;
            end
            r.data = old;
            r.illegal = !known;
            case (id)
                AddrMstatus:  mstatusM[h] = nxt;
                AddrMie:      mieM[h] = nxt;
                AddrMtvec:    mtvecM[h] = nxt;
                AddrMscratch: mscratchM[h] = nxt;
                AddrMepc:     mepcM[h] = nxt;
                AddrMcause:   mcauseM[h] = nxt;
                default: ;
            endcase
        end
    endtask

    // called on a falling edge, returns on the next one
    task automatic sendCmd(input int h, input csrOpE op, input logic [CsrIdWidth-1:0] id,
                           input logic [Xlen-1:0] d, input logic [Xlen-1:0] pc);
        respT r;
        applyModel(h, op, id, d, pc, r);
        expQ.push_back(r);
        cmdValid = 1'b1;
        cmdHart = HartW'(h);
        cmdOp = op;
        cmdCsrId = id;
        cmdData = d;
        cmdPc = pc;
        @(negedge clk);
    endtask

    task automatic drainResponses();
        cmdValid = 1'b0;
        while (expQ.size() > 0) @(negedge clk);
        @(negedge clk);
    endtask

    task automatic setTimerCmp(input int h, input logic [Xlen-1:0] value);
        tmrValid = 1'b1;
        tmrHart = HartW'(h);
        tmrCmp = value;
        @(negedge clk);
        tmrValid = 1'b0;
        repeat (3) @(negedge clk);
        // only zero and all ones are used, so mtime is always past or short of it
        pendM[h] = (value == '0);
    endtask

    function automatic logic [CsrIdWidth-1:0] csrAddrAt(input int sel);
        case (sel)
            0:       return AddrMscratch;
            1:       return AddrMtvec;
            2:       return AddrMie;
            3:       return AddrMepc;
            4:       return AddrMip;
            5:       return AddrMstatus;
            6:       return AddrMcause;
            default: return 12'h7C0;
        endcase
    endfunction

    function automatic csrOpE opAt(input int sel);
        case (sel)
            0:       return OpCsrRw;
            1:       return OpCsrRs;
            default: return OpCsrRc;
        endcase
    endfunction

    // set with a zero operand reads without changing anything
    task automatic readAll(input int h);
        for (int s = 0; s < 8; s++) begin
            sendCmd(h, OpCsrRs, csrAddrAt(s), '0, '0);
        end
    endtask

    task automatic finishTest(input string name);
        drainResponses();
        $display("test %s finished, %0d errors so far", name, errorCount);
    endtask

    initial begin
        int h;
        int sel;
        logic [Xlen-1:0] v;
        rst = 1'b1;
        cmdValid = 1'b0;
        cmdHart = '0;
        cmdOp = OpCsrRw;
        cmdCsrId = '0;
        cmdData = '0;
        cmdPc = '0;
        tmrValid = 1'b0;
        tmrHart = '0;
        tmrCmp = '0;
        for (h = 0; h < NumHarts; h++) begin
            mstatusM[h] = MstatusReset;
            mieM[h] = '0;
            mtvecM[h] = '0;
            mscratchM[h] = '0;
            mepcM[h] = '0;
            mcauseM[h] = '0;
            pendM[h] = 1'b0;
        end
        repeat (10) @(negedge clk);
        rst = 1'b0;

        for (h = 0; h < NumHarts; h++) begin
            readAll(h);
        end
        finishTest("1 reset state");

        // mip is in the mix, its writes must not stick
        repeat (160) begin
            h = $unsigned($random(seed)) % NumHarts;
            sel = $unsigned($random(seed)) % 5;
            v = {$random(seed), $random(seed)};
            sendCmd(h, opAt($unsigned($random(seed)) % 3), csrAddrAt(sel), v, '0);
        end
        for (h = 0; h < NumHarts; h++) begin
            readAll(h);
        end
        finishTest("2 csr access");

        // even harts trap with MIE set, odd harts with MIE clear
        for (h = 0; h < NumHarts; h++) begin
            sendCmd(h, OpCsrRw, AddrMtvec, 64'h8000_0103 + (Xlen'(h) << 12), '0);
            sendCmd(h, (h % 2 == 0) ? OpCsrRs : OpCsrRc, AddrMstatus, 64'h8, '0);
            sendCmd(h, OpEcall, '0, '0, 64'h8000_2000 + Xlen'(h) * 16);
            readAll(h);
            sendCmd(h, OpMret, '0, '0, '0);
            sendCmd(h, OpCsrRs, AddrMstatus, '0, '0);
        end
        finishTest("3 ecall and mret");

        setTimerCmp(1, '0);
        sendCmd(1, OpCsrRs, AddrMip, '0, '0);
        sendCmd(2, OpCsrRs, AddrMip, '0, '0);
        sendCmd(1, OpCsrRs, AddrMie, 64'h80, '0);
        sendCmd(1, OpCsrRs, AddrMstatus, 64'h8, '0);
        // this one is preempted by the interrupt
        sendCmd(1, OpCsrRw, AddrMscratch, 64'h1234_5678, 64'h8000_3000);
        sendCmd(1, OpCsrRs, AddrMcause, '0, '0);
        sendCmd(1, OpCsrRs, AddrMscratch, '0, '0);
        sendCmd(3, OpCsrRs, AddrMie, 64'h80, '0);
        sendCmd(3, OpCsrRs, AddrMstatus, 64'h8, '0);
        sendCmd(3, OpCsrRw, AddrMscratch, 64'hABCD, 64'h8000_4000);
        sendCmd(1, OpMret, '0, '0, '0);
        sendCmd(1, OpCsrRs, AddrMepc, '0, 64'h8000_3100);
        readAll(1);
        drainResponses();
        setTimerCmp(1, '1);
        finishTest("4 timer interrupt");

        repeat (48) begin
            h = $unsigned($random(seed)) % NumHarts;
            sel = $unsigned($random(seed)) % 4;
            v = {$random(seed), $random(seed)};
            sendCmd(h, opAt($unsigned($random(seed)) % 3), csrAddrAt(sel), v, '0);
        end
        finishTest("5 pipelining");

        $display("checked %0d responses, %0d errors", respChecked, errorCount);
        if (errorCount == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: trapCsrSystem.f
design/trapPkg.sv
design/csrDispatch.sv
design/machineCsrFile.sv
design/machineTimer.sv
design/responseCollect.sv
design/trapCsrSystem.sv
verif/trapCsrSystemTb.sv

// File: Bender.yml
package:
  name: trapCsrSystem

sources:
  - files:
      - design/trapPkg.sv
      - design/csrDispatch.sv
      - design/machineCsrFile.sv
      - design/machineTimer.sv
      - design/responseCollect.sv
      - design/trapCsrSystem.sv
  - target: test
    files:
      - verif/trapCsrSystemTb.sv
